//--- rtl/video_timing_pkg.sv
// Video timing definitions
// Counter width, the count type and the default 256x256 display mode

package video_timing_pkg;

  // Every horizontal and vertical counter and every mode value has this width
  localparam int COUNT_W = 12;

  // One unsigned count value, enough for totals up to 4095
  typedef logic [COUNT_W-1:0] count_t;

  // ==========================================================
  // Default mode, 256x256 active
  // ==========================================================

  // Horizontal values are in pixel clocks
  // The line is 320 clocks long in total
  localparam count_t DEF_H_DISPLAY = 12'd256;
  localparam count_t DEF_H_FP      = 12'd8;
  localparam count_t DEF_H_PULSE   = 12'd40;
  localparam count_t DEF_H_BP      = 12'd16;

  // Vertical values are in lines
  // The frame is 288 lines long in total
  localparam count_t DEF_V_DISPLAY = 12'd256;
  localparam count_t DEF_V_FP      = 12'd8;
  localparam count_t DEF_V_PULSE   = 12'd8;
  localparam count_t DEF_V_BP      = 12'd16;

  // Other standard modes are chosen by overriding the top level parameters
  // The sync pulse always comes first in each line and each frame, then the back
  // porch, the active region and the front porch

endpackage

//--- rtl/video_pixel_pkg.sv
// Video pixel definitions
// Colour channel types for the input and output side and the border colour

package video_pixel_pkg;

  // One colour channel as it arrives from the picture source
  typedef logic [3:0] nibble_t;

  // One colour channel as it leaves towards the display
  // A nibble is widened by repeating it, so 4'hF maps to full scale 8'hFF
  typedef logic [7:0] channel_t;

  // ==========================================================
  // Border colour
  // ==========================================================

  // The one-pixel frame around the picture is drawn in white
  // All three channels get this value on a border pixel
  localparam channel_t BORDER_LEVEL = 8'hFF;

endpackage

//--- rtl/line_timing.sv
`timescale 1ns/1ns

// Horizontal line timing
// Runs the pixel counter over each line and makes hs, the active-column window and strobes

module line_timing
  import video_timing_pkg::*;
#(
  parameter count_t H_DISPLAY = DEF_H_DISPLAY,
  parameter count_t H_FP      = DEF_H_FP,
  parameter count_t H_PULSE   = DEF_H_PULSE,
  parameter count_t H_BP      = DEF_H_BP
)
(
  input  logic clk,
  input  logic reset_n,
  output logic hs,
  output logic h_act,
  output logic h_last,
  output logic line_end
);

  // ==========================================================
  // Compare points
  // ==========================================================

  // Clocks per line
  // The counter runs from 0 to H_MAX
  localparam count_t H_TOTAL = H_DISPLAY + H_FP + H_PULSE + H_BP;
  localparam count_t H_MAX   = H_TOTAL - count_t'(1);

  // Last count of the sync pulse
  localparam count_t H_SYNC_LAST = H_PULSE - count_t'(1);

  // The window opens three counts before the first visible column
  // The pixel stage adds two register stages, and h_act itself is registered
  localparam count_t H_ACT_SET = H_PULSE + H_BP - count_t'(3);
  localparam count_t H_ACT_CLR = H_ACT_SET + H_DISPLAY;

  count_t h_count;

  // Strobes decoded straight from the counter
  assign line_end = (h_count == H_MAX);
  assign h_last   = (h_count == H_ACT_CLR);

  // ==========================================================
  // Counter and registered outputs
  // ==========================================================

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      // The counter waits on the last count of a line
      // The first edge after reset then opens a full sync pulse
      h_count <= H_MAX;
      hs      <= 1'b1;
      h_act   <= 1'b0;
    end
    else
    begin
      if (line_end)
        h_count <= '0;
      else
        h_count <= h_count + count_t'(1);

      // hs is low while the counter shows 0 up to H_PULSE-1
      // It is set one count early because the output is registered
      hs <= !line_end && (h_count >= H_SYNC_LAST);

      // The window stays open for exactly H_DISPLAY clocks
      if (h_count == H_ACT_SET)
        h_act <= 1'b1;
      else if (h_last)
        h_act <= 1'b0;
    end
  end

  // The counter wraps at the end of the line and never runs past it
  a_count_range: assert property (
    @(posedge clk) disable iff (!reset_n)
    h_count <= H_MAX
  );

endmodule

//--- rtl/frame_timing.sv
`timescale 1ns/1ns

// Vertical frame timing
// Steps the line counter once per line and makes vs, the active-line window and the row border

module frame_timing
  import video_timing_pkg::*;
#(
  parameter count_t V_DISPLAY = DEF_V_DISPLAY,
  parameter count_t V_FP      = DEF_V_FP,
  parameter count_t V_PULSE   = DEF_V_PULSE,
  parameter count_t V_BP      = DEF_V_BP
)
(
  input  logic clk,
  input  logic reset_n,
  input  logic line_end,
  output logic vs,
  output logic v_act,
  output logic line_border
);

  // ==========================================================
  // Compare points
  // ==========================================================

  // Lines per frame
  // The counter runs from 0 to V_MAX
  localparam count_t V_TOTAL = V_DISPLAY + V_FP + V_PULSE + V_BP;
  localparam count_t V_MAX   = V_TOTAL - count_t'(1);

  // Last line of the sync pulse
  localparam count_t V_SYNC_LAST = V_PULSE - count_t'(1);

  // The line just before the first active line
  // The window opens when the counter leaves it
  localparam count_t V_ACT_SET = V_PULSE + V_BP - count_t'(1);

  // The last active line
  // The window closes when the counter leaves it
  localparam count_t V_LAST = V_ACT_SET + V_DISPLAY;

  count_t v_count;
  logic   v_max;

  // Copy of v_act from the previous line
  logic   v_act_d;

  assign v_max = (v_count == V_MAX);

  // ==========================================================
  // Line counter and registered outputs
  // ==========================================================

  // Everything here moves on the same edge as the horizontal counter wraps
  // So vs falls together with hs, and v_act is steady for a whole line
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      // The counter waits on the last line of a frame
      // The first line after reset then opens a full vs pulse
      v_count <= V_MAX;
      vs      <= 1'b1;
      v_act   <= 1'b0;
      v_act_d <= 1'b0;
    end
    else if (line_end)
    begin
      v_act_d <= v_act;

      if (v_max)
        v_count <= '0;
      else
        v_count <= v_count + count_t'(1);

      // vs is low on lines 0 up to V_PULSE-1
      vs <= !v_max && (v_count >= V_SYNC_LAST);

      if (v_count == V_ACT_SET)
        v_act <= 1'b1;
      else if (v_count == V_LAST)
        v_act <= 1'b0;
    end
  end

  // The first active line is where the window has just opened
  // The last active line comes from the counter compare
  assign line_border = (v_act && !v_act_d) || (v_count == V_LAST);

  // The line window only moves on the edge that ends a line
  a_v_act_on_line_end: assert property (
    @(posedge clk) disable iff (!reset_n)
    $changed(v_act) |-> $past(line_end)
  );

endmodule

//--- rtl/pixel_stage.sv
`timescale 1ns/1ns

// Pixel output stage
// Makes DE, marks the one-pixel border and widens the colour nibbles to 8-bit channels

module pixel_stage
  import video_pixel_pkg::*;
(
  input  logic     clk,
  input  logic     reset_n,
  input  logic     h_act,
  input  logic     h_last,
  input  logic     v_act,
  input  logic     line_border,
  input  nibble_t  r4,
  input  nibble_t  g4,
  input  nibble_t  b4,
  output logic     de,
  output channel_t r,
  output channel_t g,
  output channel_t b
);

  // h_act one clock later, to find where the column window opens
  logic h_act_d;

  // DE one clock before it leaves the block
  logic pre_de;

  // Set on the clock before a border pixel is driven out
  logic border;

  logic h_rise;

  // High on the first count of the column window
  assign h_rise = h_act && !h_act_d;

  // ==========================================================
  // DE pipeline and colour registers
  // ==========================================================

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      h_act_d <= 1'b0;
      pre_de  <= 1'b0;
      de      <= 1'b0;
      border  <= 1'b0;
      r       <= '0;
      g       <= '0;
      b       <= '0;
    end
    else
    begin
      h_act_d <= h_act;

      // Two stages from the window to the pin, which lines de up with the columns
      pre_de <= h_act && v_act;
      de     <= pre_de;

      // First column, last column, or any column of the top and bottom rows
      // Outside the visible area the flag is set too, but de is low there
      border <= h_rise || h_last || line_border;

      // The colour inputs are taken one clock before they show on the outputs
      if (border)
      begin
        r <= BORDER_LEVEL;
        g <= BORDER_LEVEL;
        b <= BORDER_LEVEL;
      end
      else
      begin
        r <= {r4, r4};
        g <= {g4, g4};
        b <= {b4, b4};
      end
    end
  end

  // A visible pixel always belongs to a line inside the vertical window
  a_de_in_frame: assert property (
    @(posedge clk) disable iff (!reset_n)
    de |-> $past(v_act, 2)
  );

endmodule

//--- rtl/video_top.sv
`timescale 1ns/1ns

// Raster video timing generator
// Makes hs, vs and de for the chosen mode and puts a white border around the picture

module video_top
  import video_timing_pkg::*;
  import video_pixel_pkg::*;
#(
  parameter count_t H_DISPLAY = DEF_H_DISPLAY,
  parameter count_t H_FP      = DEF_H_FP,
  parameter count_t H_PULSE   = DEF_H_PULSE,
  parameter count_t H_BP      = DEF_H_BP,
  parameter count_t V_DISPLAY = DEF_V_DISPLAY,
  parameter count_t V_FP      = DEF_V_FP,
  parameter count_t V_PULSE   = DEF_V_PULSE,
  parameter count_t V_BP      = DEF_V_BP
)
(
  input  logic     clk,
  input  logic     reset_n,
  input  nibble_t  r4,
  input  nibble_t  g4,
  input  nibble_t  b4,
  output logic     hs,
  output logic     vs,
  output logic     de,
  output channel_t r,
  output channel_t g,
  output channel_t b
);

  // Column window and strobes from the line stage
  logic h_act;
  logic h_last;
  logic line_end;

  // Row window and top/bottom row flag from the frame stage
  logic v_act;
  logic line_border;

  // ==========================================================
  // Line, frame and pixel stages
  // ==========================================================

  line_timing #(
    .H_DISPLAY (H_DISPLAY),
    .H_FP      (H_FP),
    .H_PULSE   (H_PULSE),
    .H_BP      (H_BP)
  ) u_line_timing (
    .clk      (clk),
    .reset_n  (reset_n),
    .hs       (hs),
    .h_act    (h_act),
    .h_last   (h_last),
    .line_end (line_end)
  );

  // Advances one line each time the line stage wraps
  frame_timing #(
    .V_DISPLAY (V_DISPLAY),
    .V_FP      (V_FP),
    .V_PULSE   (V_PULSE),
    .V_BP      (V_BP)
  ) u_frame_timing (
    .clk         (clk),
    .reset_n     (reset_n),
    .line_end    (line_end),
    .vs          (vs),
    .v_act       (v_act),
    .line_border (line_border)
  );

  pixel_stage u_pixel_stage (
    .clk         (clk),
    .reset_n     (reset_n),
    .h_act       (h_act),
    .h_last      (h_last),
    .v_act       (v_act),
    .line_border (line_border),
    .r4          (r4),
    .g4          (g4),
    .b4          (b4),
    .de          (de),
    .r           (r),
    .g           (g),
    .b           (b)
  );

endmodule

//--- verification/video_model.svh
// Reference model of the raster video timing generator
// Tracks its own raster position and holds the typed compare tasks

`ifndef VIDEO_MODEL_SVH
`define VIDEO_MODEL_SVH

  // ==========================================================
  // Derived mode values
  // ==========================================================

  localparam int H_TOTAL    = H_DISPLAY + H_FP + H_PULSE + H_BP;
  localparam int V_TOTAL    = V_DISPLAY + V_FP + V_PULSE + V_BP;

  // The sync pulse opens each line and each frame, then the back porch follows
  localparam int FIRST_COL  = H_PULSE + H_BP;
  localparam int LAST_COL   = FIRST_COL + H_DISPLAY - 1;
  localparam int FIRST_LINE = V_PULSE + V_BP;
  localparam int LAST_LINE  = FIRST_LINE + V_DISPLAY - 1;

  // Raster position of the model
  // It is only valid once it is aligned to the first hs fall
  int hc          = 0;
  int vc          = 0;
  bit aligned     = 1'b0;
  int frames_done = 0;
  int error_count = 0;

  // Colour inputs as they stood during the previous cycle
  nibble_t prev_r4 = '0;
  nibble_t prev_g4 = '0;
  nibble_t prev_b4 = '0;

  // hs is low for the first H_PULSE counts of a line
  function automatic logic expect_hs(int h);
    return (h >= H_PULSE);
  endfunction

  // vs is low for the first V_PULSE lines of a frame
  function automatic logic expect_vs(int v);
    return (v >= V_PULSE);
  endfunction

  function automatic logic expect_de(int h, int v);
    return (v >= FIRST_LINE) && (v <= LAST_LINE) && (h >= FIRST_COL) && (h <= LAST_COL);
  endfunction

  // Outer columns and outer rows of the visible picture
  function automatic logic expect_border(int h, int v);
    return expect_de(h, v) &&
           ((h == FIRST_COL) || (h == LAST_COL) || (v == FIRST_LINE) || (v == LAST_LINE));
  endfunction

  // A nibble in both halves of a channel is the nibble scaled by 17
  function automatic channel_t widen_nibble(nibble_t n);
    return channel_t'(n) * channel_t'(8'h11);
  endfunction

  // One pixel clock further along the raster
  task automatic advance_position();
    if (hc == H_TOTAL - 1)
    begin
      hc = 0;
      if (vc == V_TOTAL - 1)
      begin
        vc = 0;
        frames_done = frames_done + 1;
      end
      else
        vc = vc + 1;
    end
    else
      hc = hc + 1;
  endtask

  // ==========================================================
  // Compare tasks
  // ==========================================================

  task automatic check_bit(string name, logic expected, logic actual);
    if (actual !== expected)
    begin
      error_count = error_count + 1;
      $display("ERROR at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
      end_with_failure();
    end
  endtask

  task automatic check_channel(string name, channel_t expected, channel_t actual);
    if (actual !== expected)
    begin
      error_count = error_count + 1;
      $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      end_with_failure();
    end
  endtask

  // Syncs idle high and no picture, as after reset
  task automatic check_quiet_outputs();
    check_bit("hs", 1'b1, hs);
    check_bit("vs", 1'b1, vs);
    check_bit("de", 1'b0, de);
  endtask

  // Full comparison at the current raster position
  task automatic check_raster_outputs();
    channel_t exp_r;
    channel_t exp_g;
    channel_t exp_b;
    check_bit("hs", expect_hs(hc), hs);
    check_bit("vs", expect_vs(vc), vs);
    check_bit("de", expect_de(hc, vc), de);
    // Colours only matter while de is high
    if (expect_de(hc, vc))
    begin
      if (expect_border(hc, vc))
      begin
        exp_r = BORDER_LEVEL;
        exp_g = BORDER_LEVEL;
        exp_b = BORDER_LEVEL;
      end
      else
      begin
        exp_r = widen_nibble(prev_r4);
        exp_g = widen_nibble(prev_g4);
        exp_b = widen_nibble(prev_b4);
      end
      check_channel("r", exp_r, r);
      check_channel("g", exp_g, g);
      check_channel("b", exp_b, b);
    end
  endtask

`endif

//--- verification/video_tb.sv
`timescale 1ns/1ns

// Testbench for the raster video timing generator
// Drives random colours and checks sync, DE, border and colour against a model

module video_tb
  import video_timing_pkg::*;
  import video_pixel_pkg::*;
;

  // ==========================================================
  // Small test mode and run length
  // ==========================================================

  localparam int H_DISPLAY = 16;
  localparam int H_FP      = 2;
  localparam int H_PULSE   = 4;
  localparam int H_BP      = 3;
  localparam int V_DISPLAY = 6;
  localparam int V_FP      = 1;
  localparam int V_PULSE   = 2;
  localparam int V_BP      = 2;

  localparam int CLK_PERIOD    = 40;
  localparam int RESET_CYCLES  = 8;
  localparam int FRAMES_TO_RUN = 3;

  logic     clk     = 1'b0;
  logic     reset_n = 1'b0;
  nibble_t  r4      = '0;
  nibble_t  g4      = '0;
  nibble_t  b4      = '0;
  logic     hs;
  logic     vs;
  logic     de;
  channel_t r;
  channel_t g;
  channel_t b;

  // Stimulus state
  // The seed is fixed so every run sees the same colours
  int          seed         = 64;
  int          reset_cycles = 0;
  logic [31:0] rand_word;

  // Stops the run after the first failure
  task automatic end_with_failure();
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped");
  endtask

  `include "video_model.svh"

  // Enough time for reset plus four whole frames
  localparam int WATCHDOG_NS = (RESET_CYCLES + 4 * H_TOTAL * V_TOTAL) * CLK_PERIOD;

  video_top #(
    .H_DISPLAY (count_t'(H_DISPLAY)),
    .H_FP      (count_t'(H_FP)),
    .H_PULSE   (count_t'(H_PULSE)),
    .H_BP      (count_t'(H_BP)),
    .V_DISPLAY (count_t'(V_DISPLAY)),
    .V_FP      (count_t'(V_FP)),
    .V_PULSE   (count_t'(V_PULSE)),
    .V_BP      (count_t'(V_BP))
  ) uut (
    .clk     (clk),
    .reset_n (reset_n),
    .r4      (r4),
    .g4      (g4),
    .b4      (b4),
    .hs      (hs),
    .vs      (vs),
    .de      (de),
    .r       (r),
    .g       (g),
    .b       (b)
  );

  always #(CLK_PERIOD / 2) clk = !clk;

  // ==========================================================
  // Stimulus on the rising edge
  // ==========================================================

  always @(posedge clk)
  begin
    rand_word = $random(seed);
    r4 <= rand_word[3:0];
    g4 <= rand_word[7:4];
    b4 <= rand_word[11:8];
    // Reset is released after eight rising edges
    if (reset_cycles == RESET_CYCLES - 1)
      reset_n <= 1'b1;
    if (reset_cycles < RESET_CYCLES)
      reset_cycles <= reset_cycles + 1;
  end

  // ==========================================================
  // Checking on the falling edge, where the outputs are stable
  // ==========================================================

  always @(negedge clk)
  begin
    if (!reset_n)
    begin
      check_quiet_outputs();
      check_channel("r", channel_t'(0), r);
      check_channel("g", channel_t'(0), g);
      check_channel("b", channel_t'(0), b);
    end
    else if (!aligned)
    begin
      // The counters leave reset on the last count of the last line with both syncs high
      // So the first hs fall opens count 0 of line 0
      if (hs === 1'b0)
      begin
        aligned = 1'b1;
        hc = 0;
        vc = 0;
        check_raster_outputs();
      end
      else
        check_quiet_outputs();
    end
    else
    begin
      advance_position();
      check_raster_outputs();
    end
    prev_r4 = r4;
    prev_g4 = g4;
    prev_b4 = b4;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("Timeout: the video frames did not complete within %0d ns", WATCHDOG_NS);
    end_with_failure();
  end

  initial
  begin
    wait (frames_done == FRAMES_TO_RUN);
    if (error_count == 0)
    begin
      $display("RESULT: PASS");
      $finish;
    end
    else
      end_with_failure();
  end

endmodule

//--- all.f
+incdir+verification
rtl/video_timing_pkg.sv
rtl/video_pixel_pkg.sv
rtl/line_timing.sv
rtl/frame_timing.sv
rtl/pixel_stage.sv
rtl/video_top.sv
verification/video_tb.sv

//--- Makefile
# Verilator build and run of the video timing testbench

TOP := video_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f all.f -Mdir obj_dir
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Test failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || { echo "No result in $(LOG)"; exit 1; }
	@echo "Test passed"

clean:
	rm -rf obj_dir $(LOG)
